//--- logic/watch_pkg.sv
package watch_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // time representation
   ////////////////////////////////////////////////////////////////////////////

   // width of one decimal digit
   localparam int BCD_W = 4;

   typedef logic [BCD_W-1:0] bcd_digit_t;

   // two decimal digits, tens on top
   typedef struct packed {
      bcd_digit_t tens;
      bcd_digit_t ones;
   } bcd_pair_t;

   // mm:ss, minutes in the upper byte
   typedef struct packed {
      bcd_pair_t min;
      bcd_pair_t sec;
   } watch_time_t;

   // button bundle, set on bit 0 like the board pinout
   typedef struct packed {
      logic inc_min;
      logic inc_sec;
      logic set;
   } btn_sel_t;

   // counter moduli
   localparam int SEC_MOD = 60;
   localparam int MIN_MOD = 60;

   ////////////////////////////////////////////////////////////////////////////
   // display
   ////////////////////////////////////////////////////////////////////////////

   // four common-anode digits
   localparam int NUM_DIGITS = 4;

   // segments active low, all dark
   localparam logic [7:0] SEG_BLANK = 8'hFF;

endpackage

//--- logic/tick_prescaler.sv
`timescale 1ns/1ps

module tick_prescaler #(
   parameter int CLKS_PER_USEC = 125,
   parameter int USEC_PER_MSEC = 1000,
   parameter int MSEC_PER_SEC  = 1000
) (
   input  logic clk,
   input  logic rst,
   output logic usec_tick,
   output logic msec_tick,
   output logic sec_tick
);

   // one spare bit so a divide by one still gets a legal width
   localparam int CLK_W  = $clog2(CLKS_PER_USEC + 1);
   localparam int USEC_W = $clog2(USEC_PER_MSEC + 1);
   localparam int MSEC_W = $clog2(MSEC_PER_SEC + 1);

   logic [CLK_W-1:0]  clk_cnt;
   logic [USEC_W-1:0] usec_cnt;
   logic [MSEC_W-1:0] msec_cnt;

   // terminal counts, each gated by the stage below
   assign usec_tick = (clk_cnt == CLK_W'(CLKS_PER_USEC - 1));
   assign msec_tick = usec_tick & (usec_cnt == USEC_W'(USEC_PER_MSEC - 1));
   assign sec_tick  = msec_tick & (msec_cnt == MSEC_W'(MSEC_PER_SEC - 1));

   ////////////////////////////////////////////////////////////////////////////
   // cascaded counters
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         clk_cnt  <= '0;
         usec_cnt <= '0;
         msec_cnt <= '0;
      end else begin
         // system clocks per microsecond
         clk_cnt <= usec_tick ? '0 : clk_cnt + 1'b1;
         // microseconds per millisecond
         if (usec_tick) begin
            usec_cnt <= msec_tick ? '0 : usec_cnt + 1'b1;
         end
         // milliseconds per second
         if (msec_tick) begin
            msec_cnt <= sec_tick ? '0 : msec_cnt + 1'b1;
         end
      end
   end

endmodule

//--- logic/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner (
   input  logic clk,
   input  logic rst,
   input  logic msec_tick,
   input  logic btn_raw,
   output logic press
);

   logic       sync_1;
   logic       sync_2;
   logic       hist;
   logic       deb;
   logic       deb_q;

   ////////////////////////////////////////////////////////////////////////////
   // two-flop synchronizer
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         sync_1 <= 1'b0;
         sync_2 <= 1'b0;
      end else begin
         sync_1 <= btn_raw;
         sync_2 <= sync_1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // debounce on the millisecond sample
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         hist <= 1'b0;
         deb  <= 1'b0;
      end else if (msec_tick) begin
         hist <= sync_2;
         // two highs in a row set the level
         if (hist && sync_2) begin
            deb <= 1'b1;
         // two lows in a row clear it, anything else holds
         end else if (!hist && !sync_2) begin
            deb <= 1'b0;
         end
      end
   end

   // rising edge of the debounced level, one cycle late
   always_ff @(posedge clk) begin
      if (rst) begin
         deb_q <= 1'b0;
         press <= 1'b0;
      end else begin
         deb_q <= deb;
         press <= deb & ~deb_q;
      end
   end

endmodule

//--- logic/bcd_mod_counter.sv
`timescale 1ns/1ps

module bcd_mod_counter
   import watch_pkg::*;
#(
   parameter int MODULUS = 60
) (
   input  logic      clk,
   input  logic      rst,
   input  logic      inc,
   input  logic      load,
   input  bcd_pair_t load_value,
   output bcd_pair_t value,
   output logic      wrap
);

   // last legal count, split into digits
   localparam bcd_digit_t LAST_TENS = bcd_digit_t'((MODULUS - 1) / 10);
   localparam bcd_digit_t LAST_ONES = bcd_digit_t'((MODULUS - 1) % 10);

   logic at_last;
   logic ones_nine;

   assign at_last   = (value.tens == LAST_TENS) && (value.ones == LAST_ONES);
   assign ones_nine = (value.ones == bcd_digit_t'(9));

   // carry out for the next stage, same cycle as the roll to 00
   assign wrap = inc & at_last;

   ////////////////////////////////////////////////////////////////////////////
   // count register
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         value <= '0;
      end else if (load) begin
         // parallel load wins over inc
         value <= load_value;
      end else if (inc) begin
         if (at_last) begin
            value <= '0;
         end else if (ones_nine) begin
            // decimal roll into the tens digit
            value.tens <= value.tens + 1'b1;
            value.ones <= '0;
         end else begin
            value.ones <= value.ones + 1'b1;
         end
      end
   end

endmodule

//--- logic/watch_core.sv
`timescale 1ns/1ps

module watch_core
   import watch_pkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        sec_tick,
   input  logic        set_press,
   input  logic        sec_press,
   input  logic        min_press,
   output watch_time_t shown_time
);

   logic      set_mode;
   logic      enter_set;
   logic      leave_set;
   logic      sec_wrap;
   logic      edit_sec_inc;
   logic      edit_min_inc;
   bcd_pair_t run_sec_val;
   bcd_pair_t run_min_val;
   bcd_pair_t edit_sec_val;
   bcd_pair_t edit_min_val;

   ////////////////////////////////////////////////////////////////////////////
   // set mode toggle
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         set_mode <= 1'b0;
      end else if (set_press) begin
         set_mode <= ~set_mode;
      end
   end

   // mode transitions, valid only in the press cycle
   assign enter_set = set_press & ~set_mode;
   assign leave_set = set_press & set_mode;

   // buttons only touch the edit pair while editing
   assign edit_sec_inc = sec_press & set_mode;
   assign edit_min_inc = min_press & set_mode;

   ////////////////////////////////////////////////////////////////////////////
   // running time
   ////////////////////////////////////////////////////////////////////////////

   // keeps counting in set mode, picks up the edit on exit
   bcd_mod_counter #(
      .MODULUS (SEC_MOD)
   ) run_sec (
      .clk        (clk),
      .rst        (rst),
      .inc        (sec_tick),
      .load       (leave_set),
      .load_value (edit_sec_val),
      .value      (run_sec_val),
      .wrap       (sec_wrap)
   );

   // minutes only move on the seconds carry
   bcd_mod_counter #(
      .MODULUS (MIN_MOD)
   ) run_min (
      .clk        (clk),
      .rst        (rst),
      .inc        (sec_wrap),
      .load       (leave_set),
      .load_value (edit_min_val),
      .value      (run_min_val),
      .wrap       ()
   );

   ////////////////////////////////////////////////////////////////////////////
   // edit time
   ////////////////////////////////////////////////////////////////////////////

   // snapshot of the running time on entry
   bcd_mod_counter #(
      .MODULUS (SEC_MOD)
   ) edit_sec (
      .clk        (clk),
      .rst        (rst),
      .inc        (edit_sec_inc),
      .load       (enter_set),
      .load_value (run_sec_val),
      .value      (edit_sec_val),
      .wrap       ()
   );

   // no carry from edit seconds
   bcd_mod_counter #(
      .MODULUS (MIN_MOD)
   ) edit_min (
      .clk        (clk),
      .rst        (rst),
      .inc        (edit_min_inc),
      .load       (enter_set),
      .load_value (run_min_val),
      .value      (edit_min_val),
      .wrap       ()
   );

   // display follows whichever pair is live
   assign shown_time = set_mode ? {edit_min_val, edit_sec_val}
                                : {run_min_val, run_sec_val};

endmodule

//--- logic/fnd_scanner.sv
`timescale 1ns/1ps

module fnd_scanner
   import watch_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  msec_tick,
   input  watch_time_t           shown_time,
   output logic [NUM_DIGITS-1:0] com,
   output logic [7:0]            seg_7
);

   localparam int IDX_W = $clog2(NUM_DIGITS);

   logic [IDX_W-1:0] digit_idx;
   bcd_digit_t       digit_val;

   // active-low segments, bit 7 is the dot and stays dark
   function automatic logic [7:0] seg_decode(bcd_digit_t d);
      logic [7:0] s;
      case (d)
         4'd0:    s = 8'b1100_0000;
         4'd1:    s = 8'b1111_1001;
         4'd2:    s = 8'b1010_0100;
         4'd3:    s = 8'b1011_0000;
         4'd4:    s = 8'b1001_1001;
         4'd5:    s = 8'b1001_0010;
         4'd6:    s = 8'b1000_0010;
         4'd7:    s = 8'b1111_1000;
         4'd8:    s = 8'b1000_0000;
         4'd9:    s = 8'b1001_0000;
         // not a decimal digit
         default: s = SEG_BLANK;
      endcase
      return s;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // digit scan
   ////////////////////////////////////////////////////////////////////////////

   // one digit per millisecond, index rolls over by width
   always_ff @(posedge clk) begin
      if (rst) begin
         digit_idx <= '0;
      end else if (msec_tick) begin
         digit_idx <= digit_idx + 1'b1;
      end
   end

   // rightmost digit first
   always_comb begin
      case (digit_idx)
         2'd0:    digit_val = shown_time.sec.ones;
         2'd1:    digit_val = shown_time.sec.tens;
         2'd2:    digit_val = shown_time.min.ones;
         default: digit_val = shown_time.min.tens;
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // output registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         // digit 0 lit, showing zero
         com   <= ~NUM_DIGITS'(1);
         seg_7 <= seg_decode('0);
      end else begin
         // one-hot low enable
         com   <= ~(NUM_DIGITS'(1) << digit_idx);
         seg_7 <= seg_decode(digit_val);
      end
   end

endmodule

//--- logic/watch_top.sv
`timescale 1ns/1ps

module watch_top
   import watch_pkg::*;
#(
   parameter int CLKS_PER_USEC = 125,
   parameter int USEC_PER_MSEC = 1000,
   parameter int MSEC_PER_SEC  = 1000
) (
   input  logic                  clk,
   input  logic                  rst,
   input  btn_sel_t              btn,
   output logic [NUM_DIGITS-1:0] com,
   output logic [7:0]            seg_7
);

   logic        msec_tick;
   logic        sec_tick;
   logic        set_press;
   logic        sec_press;
   logic        min_press;
   watch_time_t shown_time;

   ////////////////////////////////////////////////////////////////////////////
   // time base
   ////////////////////////////////////////////////////////////////////////////

   // microsecond tick stays internal to the divider chain
   tick_prescaler #(
      .CLKS_PER_USEC (CLKS_PER_USEC),
      .USEC_PER_MSEC (USEC_PER_MSEC),
      .MSEC_PER_SEC  (MSEC_PER_SEC)
   ) prescaler (
      .clk       (clk),
      .rst       (rst),
      .usec_tick (),
      .msec_tick (msec_tick),
      .sec_tick  (sec_tick)
   );

   ////////////////////////////////////////////////////////////////////////////
   // buttons
   ////////////////////////////////////////////////////////////////////////////

   button_conditioner set_btn (
      .clk       (clk),
      .rst       (rst),
      .msec_tick (msec_tick),
      .btn_raw   (btn.set),
      .press     (set_press)
   );

   button_conditioner sec_btn (
      .clk       (clk),
      .rst       (rst),
      .msec_tick (msec_tick),
      .btn_raw   (btn.inc_sec),
      .press     (sec_press)
   );

   button_conditioner min_btn (
      .clk       (clk),
      .rst       (rst),
      .msec_tick (msec_tick),
      .btn_raw   (btn.inc_min),
      .press     (min_press)
   );

   ////////////////////////////////////////////////////////////////////////////
   // counters and display
   ////////////////////////////////////////////////////////////////////////////

   watch_core core (
      .clk        (clk),
      .rst        (rst),
      .sec_tick   (sec_tick),
      .set_press  (set_press),
      .sec_press  (sec_press),
      .min_press  (min_press),
      .shown_time (shown_time)
   );

   fnd_scanner scanner (
      .clk        (clk),
      .rst        (rst),
      .msec_tick  (msec_tick),
      .shown_time (shown_time),
      .com        (com),
      .seg_7      (seg_7)
   );

endmodule

//--- verification/watch_tb.sv
`timescale 1ns/1ps

module watch_tb
   import watch_pkg::*;
;

   // scaled time base, 8 cycles per msec and 40 per second
   localparam int CYC_PER_SEC  = 40;
   localparam int HOLD_CYCLES  = 40;
   localparam int PRESS_CYCLES = 2 * HOLD_CYCLES;
   localparam int MAX_INCS     = 70;

   // phase lengths in cycles, timeout with 20 percent margin
   localparam int COUNT_PHASE    = (3600 + 2) * CYC_PER_SEC;
   localparam int EDIT_PHASE     = (2 * MAX_INCS + 2) * PRESS_CYCLES + 68 * CYC_PER_SEC;
   localparam int RESUME_PHASE   = 3 * PRESS_CYCLES + 10 * CYC_PER_SEC;
   localparam int TIMEOUT_CYCLES = (COUNT_PHASE + EDIT_PHASE + RESUME_PHASE) * 12 / 10;

   localparam btn_sel_t PRESS_SET     = '{inc_min: 1'b0, inc_sec: 1'b0, set: 1'b1};
   localparam btn_sel_t PRESS_INC_SEC = '{inc_min: 1'b0, inc_sec: 1'b1, set: 1'b0};
   localparam btn_sel_t PRESS_INC_MIN = '{inc_min: 1'b1, inc_sec: 1'b0, set: 1'b0};

   logic                  clk = 1'b0;
   logic                  rst;
   btn_sel_t              btn;
   logic [NUM_DIGITS-1:0] com;
   logic [7:0]            seg_7;

   // cycle and tick bookkeeping, written at posedge only
   int   cyc = 0;
   int   sec_ticks = 0;
   logic scan_on = 1'b0;

   // display image, written at negedge only
   logic [15:0] image = '0;
   int          seen_at [NUM_DIGITS];
   int          last_pos = 0;
   int          dwell = 0;
   int          pos;
   int          dig;

   // running time reference
   int     run_base = 0;
   int     tick_base = 0;
   int     captured;
   int     edit_time;
   int     n_sec;
   int     n_min;
   integer seed = 32'h9530_b768;

   watch_top #(
      .CLKS_PER_USEC (2),
      .USEC_PER_MSEC (4),
      .MSEC_PER_SEC  (5)
   ) UUT (
      .clk   (clk),
      .rst   (rst),
      .btn   (btn),
      .com   (com),
      .seg_7 (seg_7)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_error(input string msg);
      $display("[ERROR] %0t %s", $time, msg);
      $display("test failed");
      $fatal(1, "stopped at first error");
   endtask

   // active-low segment pattern back to a digit, -1 if none
   function automatic int digit_of_segments(input logic [7:0] s);
      case (s)
         8'hC0:   return 0;
         8'hF9:   return 1;
         8'hA4:   return 2;
         8'hB0:   return 3;
         8'h99:   return 4;
         8'h92:   return 5;
         8'h82:   return 6;
         8'hF8:   return 7;
         8'h80:   return 8;
         8'h90:   return 9;
         default: return -1;
      endcase
   endfunction

   function automatic int position_of(input logic [NUM_DIGITS-1:0] enables);
      int p;
      int i;
      p = 0;
      for (i = 0; i < NUM_DIGITS; i++) begin
         if (!enables[i]) begin
            p = i;
         end
      end
      return p;
   endfunction

   // total seconds to the mm:ss digit image
   function automatic logic [15:0] to_image(input int total);
      int mins;
      int secs;
      mins = total / 60;
      secs = total % 60;
      return {4'(mins / 10), 4'(mins % 10), 4'(secs / 10), 4'(secs % 10)};
   endfunction

   // expected running time, one step per 40-cycle tick since the last load
   function automatic int run_time();
      return (run_base + sec_ticks - tick_base) % 3600;
   endfunction

   function automatic logic all_seen_after(input int start);
      int i;
      for (i = 0; i < NUM_DIGITS; i++) begin
         if (seen_at[i] <= start) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   // next negedge two cycles past a sec tick
   task automatic align_second();
      do @(negedge clk); while (cyc % CYC_PER_SEC != 2);
   endtask

   task automatic press_button(input btn_sel_t which);
      btn = which;
      repeat (HOLD_CYCLES) @(negedge clk);
      btn = '0;
      repeat (HOLD_CYCLES) @(negedge clk);
   endtask

   // full fresh scan, then compare at posedge where the image is stable
   task automatic check_display(input logic [15:0] expected, input string what);
      int start;
      start = cyc;
      do @(posedge clk); while (!all_seen_after(start));
      assert (image == expected)
         else report_error($sformatf("%s: display %h, expected %h", what, image, expected));
      @(negedge clk);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // cycle count, tick model and timeout
   ////////////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (!rst) begin
         cyc     <= cyc + 1;
         scan_on <= 1'b1;
         // sec tick lands on every 40th cycle after reset release
         if ((cyc + 1) % CYC_PER_SEC == 0) begin
            sec_ticks <= sec_ticks + 1;
         end
         if (cyc + 1 >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $fatal(1, "stopped on timeout");
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // display decoder model
   ////////////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin
      if (scan_on) begin
         assert ($onehot(~com))
            else report_error($sformatf("com %b is not one-hot low", com));
         pos = position_of(com);
         dig = digit_of_segments(seg_7);
         assert (dig >= 0)
            else report_error($sformatf("seg_7 %h is no decimal digit", seg_7));
         image[pos*4 +: 4] = 4'(dig);
         seen_at[pos] = cyc;
         // scan order 0,1,2,3 with 8 samples per digit
         if (pos == last_pos) begin
            dwell = dwell + 1;
         end else begin
            assert (pos == (last_pos + 1) % NUM_DIGITS && dwell == 8)
               else report_error($sformatf("scan moved %0d->%0d after %0d cycles",
                                           last_pos, pos, dwell));
            dwell = 1;
         end
         last_pos = pos;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      foreach (seen_at[i]) seen_at[i] = -1;
      rst = 1'b1;
      btn = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // all zeros before the first tick
      check_display(to_image(0), "after reset");

      // free run through a full hour, checked every second
      for (int k = 1; k <= 3600; k++) begin
         align_second();
         check_display(to_image(run_time()), $sformatf("free run second %0d", k));
      end

      // wait for seconds at 59 so any seconds edit has to wrap
      do begin
         align_second();
      end while (run_time() % 60 != 59);

      // enter set mode, snapshot then frozen
      captured = run_time();
      press_button(PRESS_SET);
      check_display(to_image(captured), "set mode entry");
      repeat (3) begin
         align_second();
         check_display(to_image(captured), "set mode frozen");
      end

      // edit minutes and seconds independently
      n_sec = 1 + int'($unsigned($random(seed)) % MAX_INCS);
      n_min = 1 + int'($unsigned($random(seed)) % MAX_INCS);
      repeat (n_sec) press_button(PRESS_INC_SEC);
      repeat (n_min) press_button(PRESS_INC_MIN);
      edit_time = ((captured / 60 + n_min) % 60) * 60 + (captured % 60 + n_sec) % 60;
      check_display(to_image(edit_time), "edited time");

      // leave set mode, running pair takes the edit before the next tick
      align_second();
      run_base  = edit_time;
      tick_base = sec_ticks;
      press_button(PRESS_SET);
      check_display(to_image(run_time()), "set mode exit");
      repeat (5) begin
         align_second();
         check_display(to_image(run_time()), "resumed count");
      end

      // increments ignored while running
      align_second();
      press_button(PRESS_INC_SEC);
      check_display(to_image(run_time()), "inc sec outside set mode");
      align_second();
      press_button(PRESS_INC_MIN);
      check_display(to_image(run_time()), "inc min outside set mode");

      $display("test passed");
      $finish;
   end

endmodule

//--- src.f
logic/watch_pkg.sv
logic/tick_prescaler.sv
logic/button_conditioner.sv
logic/bcd_mod_counter.sv
logic/watch_core.sv
logic/fnd_scanner.sv
logic/watch_top.sv
verification/watch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the watch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module watch_tb -f src.f -o watch_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/watch_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "test failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi

if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if ! grep -q "test passed" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

echo "simulation PASSED"
exit 0
